// ==== compile.f ====
verilog/aimbot_pkg.sv
verilog/cam_byte_packer.sv
verilog/frame_timing.sv
verilog/box_overlay.sv
verilog/aim_ctrl.sv
verilog/aimbot_top.sv
tb/aimbot_asserts.sv
tb/tb_aimbot.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f compile.f \
    --top-module tb_aimbot -o sim_aimbot \
    && ./obj_dir/sim_aimbot > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tb/aimbot_asserts.sv ====
`timescale 1ns/1ns

module aimbot_asserts (
    input logic                i_clk,
    input logic                i_rst,
    input aimbot_pkg::rgb888_t i_disp_rgb,
    input logic                i_disp_de,
    input logic                i_disp_hsync,
    input logic                i_disp_vsync
);

    // Pixels only travel inside an active line of an active frame.
    de_in_vblank: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_disp_de && i_disp_vsync)) else $error("Data enable high during vertical sync.");

    de_in_hblank: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_disp_de && !i_disp_hsync)) else $error("Data enable high outside a line.");

    outputs_known: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown({i_disp_rgb, i_disp_de, i_disp_hsync, i_disp_vsync}))
        else $error("Display output unknown after reset.");

endmodule

bind aimbot_top aimbot_asserts u_asserts (
    .i_clk(i_clk), .i_rst(i_rst), .i_disp_rgb(o_disp_rgb),
    .i_disp_de(o_disp_de), .i_disp_hsync(o_disp_hsync), .i_disp_vsync(o_disp_vsync)
);

// ==== tb/tb_aimbot.sv ====
`timescale 1ns/1ns

module tb_aimbot;

    localparam int COLS = 16;
    localparam int ROWS = 8;
    localparam int H_W = 2;
    localparam int V_W = 1;
    localparam int LINE_CYCLES = 2 * COLS + 4;
    localparam int FRAME_CYCLES = 12 + ROWS * LINE_CYCLES + 16;
    localparam int TIMEOUT_CYCLES = 4 * 8 * FRAME_CYCLES;   // All tests send eight frames.
    localparam logic [15:0] PAT_PIX [4] = '{16'hF800, 16'h07E0, 16'h001F, 16'h8410};
    localparam logic [23:0] PAT_RGB [4] = '{24'hF80000, 24'h00FC00, 24'h0000F8, 24'h808080};

    logic i_clk, i_rst;
    logic i_cam1_vsync, i_cam1_href, i_cam1_pclk_en;
    logic i_cam2_vsync, i_cam2_href, i_cam2_pclk_en;
    logic [7:0] i_cam1_data, i_cam2_data;
    logic i_cfg_we;
    aimbot_pkg::cfg_addr_t i_cfg_addr;
    aimbot_pkg::cfg_data_t i_cfg_data;
    aimbot_pkg::rgb888_t o_disp_rgb;
    logic o_disp_de, o_disp_hsync, o_disp_vsync;

    // Register map as software sees it, pending and active.
    logic [15:0] pend_reg [11];
    logic [15:0] act_reg [11];
    aimbot_pkg::rgb888_t exp_q [$];
    int shown_pix, value_errs, count_errs, other_errs, cycles;

    aimbot_top #(.N_BOX(2), .H_BOX_WIDTH(H_W), .V_BOX_WIDTH(V_W)) i_dut (.*);

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_rgb(input aimbot_pkg::rgb888_t got, input aimbot_pkg::rgb888_t exp,
                             input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            count_errs++;
        end
    endtask

    function automatic aimbot_pkg::rgb888_t expect_pixel(input int x, input int y,
                                                         input logic [15:0] pix);
        int sx, sy, ex, ey;
        for (int k = 0; k < 2; k++) begin
            sx = int'(act_reg[4 * k]);
            sy = int'(act_reg[4 * k + 1]);
            ex = int'(act_reg[4 * k + 2]);
            ey = int'(act_reg[4 * k + 3]);
            if (act_reg[10][1 + k] && x >= sx && x <= ex && y >= sy && y <= ey &&
                (x < sx + H_W || x > ex - H_W || y < sy + V_W || y > ey - V_W)) begin
                return {act_reg[9][7:0], act_reg[8]};
            end
        end
        return {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000};
    endfunction

    task automatic cfg_write(input int addr, input int data);
        @(posedge i_clk);
        i_cfg_we   <= 1'b1;
        i_cfg_addr <= 4'(addr);
        i_cfg_data <= 16'(data);
        pend_reg[addr] = 16'(data);
        @(posedge i_clk);
        i_cfg_we <= 1'b0;
    endtask

    task automatic set_box(input int k, input int sx, input int sy, input int ex, input int ey);
        cfg_write(4 * k, sx);
        cfg_write(4 * k + 1, sy);
        cfg_write(4 * k + 2, ex);
        cfg_write(4 * k + 3, ey);
    endtask

    // Both cameras run in lockstep, each with its own pixel data.
    task automatic drive_blank(input logic vsync, input int n);
        @(posedge i_clk);
        i_cam1_href    <= 1'b0;
        i_cam2_href    <= 1'b0;
        i_cam1_pclk_en <= 1'b0;
        i_cam2_pclk_en <= 1'b0;
        i_cam1_vsync   <= vsync;
        i_cam2_vsync   <= vsync;
        repeat (n - 1) @(posedge i_clk);
    endtask

    task automatic send_pixel(input logic [15:0] p1, input logic [15:0] p2);
        for (int i = 1; i >= 0; i--) begin
            @(posedge i_clk);
            i_cam1_href    <= 1'b1;
            i_cam2_href    <= 1'b1;
            i_cam1_pclk_en <= 1'b1;
            i_cam2_pclk_en <= 1'b1;
            i_cam1_data    <= p1[8 * i +: 8];   // High byte first.
            i_cam2_data    <= p2[8 * i +: 8];
        end
    endtask

    // The pattern frame expects literal colours, so it runs on camera 1 with no box enabled.
    task automatic send_frame(input bit pattern);
        logic [15:0] p1, p2;
        int first;
        first = shown_pix;
        drive_blank(1'b1, 6);
        check_bit(o_disp_vsync, 1'b1, "o_disp_vsync");
        check_bit(o_disp_hsync, 1'b0, "o_disp_hsync");
        drive_blank(1'b0, 6);
        check_bit(o_disp_vsync, 1'b0, "o_disp_vsync");
        act_reg = pend_reg;
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                p1 = pattern ? PAT_PIX[x % 4] : 16'($urandom());
                p2 = 16'($urandom());
                exp_q.push_back(pattern ? PAT_RGB[x % 4] :
                                expect_pixel(x, y, act_reg[10][0] ? p2 : p1));
                send_pixel(p1, p2);
            end
            drive_blank(1'b0, 4);
        end
        drive_blank(1'b1, 1);
        for (int i = 0; i < 16 && exp_q.size() != 0; i++) begin
            @(posedge i_clk);
        end
        check_count(shown_pix - first, ROWS * COLS, "pixels per frame");
    endtask

    task automatic watch_display();
        forever begin
            @(posedge i_clk);
            if (o_disp_de) begin
                shown_pix++;
                check_bit(o_disp_hsync, 1'b1, "o_disp_hsync");
                check_bit(o_disp_vsync, 1'b0, "o_disp_vsync");
                if (exp_q.size() == 0) begin
                    $display("Display sent a pixel at %0t when none was expected", $time);
                    other_errs++;
                end else begin
                    check_rgb(o_disp_rgb, exp_q.pop_front(), "o_disp_rgb");
                end
            end
        end
    endtask

    task automatic plain_frames();
        check_bit(o_disp_de, 1'b0, "o_disp_de");
        check_bit(o_disp_hsync, 1'b0, "o_disp_hsync");
        check_bit(o_disp_vsync, 1'b0, "o_disp_vsync");
        send_frame(1'b0);
    endtask

    task automatic box_borders();
        set_box(0, 3, 2, 10, 6);
        cfg_write(8, 16'h5AC3);   // Low colour bits no camera pixel can produce.
        cfg_write(9, 16'h00A5);
        cfg_write(10, 16'h0002);
        send_frame(1'b0);
    endtask

    task automatic frame_boundary_update();
        fork
            send_frame(1'b0);
            begin
                repeat (12 + 3 * LINE_CYCLES) @(posedge i_clk);
                set_box(0, 1, 0, 6, 3);
            end
        join
        send_frame(1'b0);
    endtask

    task automatic two_boxes();
        set_box(0, 3, 2, 10, 6);
        set_box(1, 8, 4, 14, 7);
        cfg_write(10, 16'h0006);   // Also returns to camera 1.
        send_frame(1'b0);
        cfg_write(10, 16'h0002);
        send_frame(1'b0);
    endtask

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        {i_cam1_vsync, i_cam1_href, i_cam1_pclk_en, i_cam1_data} = {3'b100, 8'h00};
        {i_cam2_vsync, i_cam2_href, i_cam2_pclk_en, i_cam2_data} = {3'b100, 8'h00};
        i_cfg_we = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        pend_reg = '{default: 16'h0000};
        act_reg = '{default: 16'h0000};
        void'($urandom(32'h5a2b900a));
        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        fork
            watch_display();
        join_none
        plain_frames();
        send_frame(1'b1);
        box_borders();
        frame_boundary_update();
        cfg_write(10, 16'h0001);
        send_frame(1'b0);
        two_boxes();
        $display("Summary: %0d value errors, %0d count errors, %0d other errors",
                 value_errs, count_errs, other_errs);
        if (value_errs + count_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog/aim_ctrl.sv ====
`timescale 1ns/1ns

module aim_ctrl #(
    parameter int N_BOX = 2
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_cfg_we,
    input  aimbot_pkg::cfg_addr_t i_cfg_addr,
    input  aimbot_pkg::cfg_data_t i_cfg_data,
    input  logic                  i_frame_start,
    output logic                  o_cam_sel,
    output logic                  o_box_en [N_BOX],
    output aimbot_pkg::xcoord_t   o_start_x [N_BOX],
    output aimbot_pkg::ycoord_t   o_start_y [N_BOX],
    output aimbot_pkg::xcoord_t   o_end_x [N_BOX],
    output aimbot_pkg::ycoord_t   o_end_y [N_BOX],
    output aimbot_pkg::rgb888_t   o_color
);

    // Pending copy, written by software at any time.
    logic                pend_cam_sel;
    logic                pend_box_en [N_BOX];
    aimbot_pkg::xcoord_t pend_start_x [N_BOX];
    aimbot_pkg::ycoord_t pend_start_y [N_BOX];
    aimbot_pkg::xcoord_t pend_end_x [N_BOX];
    aimbot_pkg::ycoord_t pend_end_y [N_BOX];
    aimbot_pkg::rgb888_t pend_color;

    logic [1:0] box_sel;
    logic [1:0] box_field;
    logic       box_region;

    assign box_sel    = i_cfg_addr[3:2];
    assign box_field  = i_cfg_addr[1:0];
    assign box_region = int'(i_cfg_addr) < 4 * aimbot_pkg::MAX_BOX;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pend_cam_sel <= 1'b0;
            pend_box_en  <= '{default: 1'b0};
            pend_start_x <= '{default: '0};
            pend_start_y <= '{default: '0};
            pend_end_x   <= '{default: '0};
            pend_end_y   <= '{default: '0};
            pend_color   <= '0;
        end else if (i_cfg_we) begin
            if (box_region) begin
                // Boxes above N_BOX have no registers and drop the write.
                for (int k = 0; k < N_BOX; k++) begin
                    if (int'(box_sel) == k) begin
                        case (box_field)
                            aimbot_pkg::CFG_BOX_START_X: pend_start_x[k] <= i_cfg_data[10:0];
                            aimbot_pkg::CFG_BOX_START_Y: pend_start_y[k] <= i_cfg_data[9:0];
                            aimbot_pkg::CFG_BOX_END_X:   pend_end_x[k]   <= i_cfg_data[10:0];
                            default:                     pend_end_y[k]   <= i_cfg_data[9:0];
                        endcase
                    end
                end
            end else begin
                case (i_cfg_addr)
                    aimbot_pkg::CFG_COLOR_LO: begin
                        pend_color.g <= i_cfg_data[15:8];
                        pend_color.b <= i_cfg_data[7:0];
                    end
                    aimbot_pkg::CFG_COLOR_HI: pend_color.r <= i_cfg_data[7:0];
                    aimbot_pkg::CFG_CTRL: begin
                        pend_cam_sel <= i_cfg_data[aimbot_pkg::CTRL_CAM_SEL];
                        for (int k = 0; k < N_BOX; k++) begin
                            pend_box_en[k] <= i_cfg_data[aimbot_pkg::CTRL_BOX_EN + k];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // The active copy only moves between frames.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cam_sel <= 1'b0;
            o_box_en  <= '{default: 1'b0};
            o_start_x <= '{default: '0};
            o_start_y <= '{default: '0};
            o_end_x   <= '{default: '0};
            o_end_y   <= '{default: '0};
            o_color   <= '0;
        end else if (i_frame_start) begin
            o_cam_sel <= pend_cam_sel;
            o_box_en  <= pend_box_en;
            o_start_x <= pend_start_x;
            o_start_y <= pend_start_y;
            o_end_x   <= pend_end_x;
            o_end_y   <= pend_end_y;
            o_color   <= pend_color;
        end
    end

endmodule

// ==== verilog/aimbot_pkg.sv ====
package aimbot_pkg;

    // RGB565 as the camera sends it, red in the top bits.
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pix565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef logic [10:0] xcoord_t;
    typedef logic [9:0]  ycoord_t;
    typedef logic [3:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    localparam int MAX_BOX = 2;

    // Field offsets inside the four addresses of one box.
    localparam logic [1:0] CFG_BOX_START_X = 2'd0;
    localparam logic [1:0] CFG_BOX_START_Y = 2'd1;
    localparam logic [1:0] CFG_BOX_END_X   = 2'd2;
    localparam logic [1:0] CFG_BOX_END_Y   = 2'd3;

    localparam cfg_addr_t CFG_COLOR_LO = 4'd8;   // Green high byte, blue low byte.
    localparam cfg_addr_t CFG_COLOR_HI = 4'd9;   // Red low byte.
    localparam cfg_addr_t CFG_CTRL     = 4'd10;

    // Bit positions in the control register.
    localparam int CTRL_CAM_SEL = 0;
    localparam int CTRL_BOX_EN  = 1;

endpackage

// ==== verilog/aimbot_top.sv ====
`timescale 1ns/1ns

module aimbot_top #(
    parameter int N_BOX       = 2,
    parameter int H_BOX_WIDTH = 2,
    parameter int V_BOX_WIDTH = 1
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_cam1_vsync,
    input  logic                  i_cam1_href,
    input  logic                  i_cam1_pclk_en,
    input  logic [7:0]            i_cam1_data,
    input  logic                  i_cam2_vsync,
    input  logic                  i_cam2_href,
    input  logic                  i_cam2_pclk_en,
    input  logic [7:0]            i_cam2_data,
    input  logic                  i_cfg_we,
    input  aimbot_pkg::cfg_addr_t i_cfg_addr,
    input  aimbot_pkg::cfg_data_t i_cfg_data,
    output aimbot_pkg::rgb888_t   o_disp_rgb,
    output logic                  o_disp_de,
    output logic                  o_disp_hsync,
    output logic                  o_disp_vsync
);

    aimbot_pkg::pix565_t cam1_pix, cam2_pix, ft_pix;
    logic                cam1_valid, cam1_href, cam1_vsync;
    logic                cam2_valid, cam2_href, cam2_vsync;

    logic                cam_sel;
    logic                frame_start;
    logic                box_en [N_BOX];
    aimbot_pkg::xcoord_t start_x [N_BOX];
    aimbot_pkg::ycoord_t start_y [N_BOX];
    aimbot_pkg::xcoord_t end_x [N_BOX];
    aimbot_pkg::ycoord_t end_y [N_BOX];
    aimbot_pkg::rgb888_t color;

    aimbot_pkg::xcoord_t ft_x;
    aimbot_pkg::ycoord_t ft_y;
    logic                ft_de, ft_hsync, ft_vsync;

    cam_byte_packer u_cam1_packer (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_href(i_cam1_href), .i_vsync(i_cam1_vsync),
        .i_pclk_en(i_cam1_pclk_en), .i_data(i_cam1_data),
        .o_pix(cam1_pix), .o_pix_valid(cam1_valid),
        .o_href(cam1_href), .o_vsync(cam1_vsync)
    );

    cam_byte_packer u_cam2_packer (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_href(i_cam2_href), .i_vsync(i_cam2_vsync),
        .i_pclk_en(i_cam2_pclk_en), .i_data(i_cam2_data),
        .o_pix(cam2_pix), .o_pix_valid(cam2_valid),
        .o_href(cam2_href), .o_vsync(cam2_vsync)
    );

    aim_ctrl #(.N_BOX(N_BOX)) u_ctrl (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_cfg_we(i_cfg_we), .i_cfg_addr(i_cfg_addr), .i_cfg_data(i_cfg_data),
        .i_frame_start(frame_start),
        .o_cam_sel(cam_sel), .o_box_en(box_en),
        .o_start_x(start_x), .o_start_y(start_y),
        .o_end_x(end_x), .o_end_y(end_y), .o_color(color)
    );

    frame_timing u_timing (
        .i_clk(i_clk), .i_rst(i_rst), .i_cam_sel(cam_sel),
        .i_cam1_pix(cam1_pix), .i_cam1_pix_valid(cam1_valid),
        .i_cam1_href(cam1_href), .i_cam1_vsync(cam1_vsync),
        .i_cam2_pix(cam2_pix), .i_cam2_pix_valid(cam2_valid),
        .i_cam2_href(cam2_href), .i_cam2_vsync(cam2_vsync),
        .o_x(ft_x), .o_y(ft_y), .o_pix(ft_pix), .o_de(ft_de),
        .o_hsync(ft_hsync), .o_vsync(ft_vsync), .o_frame_start(frame_start)
    );

    box_overlay #(
        .N_BOX(N_BOX), .H_BOX_WIDTH(H_BOX_WIDTH), .V_BOX_WIDTH(V_BOX_WIDTH)
    ) u_overlay (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_x(ft_x), .i_y(ft_y), .i_pix(ft_pix), .i_de(ft_de),
        .i_hsync(ft_hsync), .i_vsync(ft_vsync),
        .i_start_x(start_x), .i_start_y(start_y),
        .i_end_x(end_x), .i_end_y(end_y),
        .i_box_en(box_en), .i_color(color),
        .o_rgb(o_disp_rgb), .o_de(o_disp_de),
        .o_hsync(o_disp_hsync), .o_vsync(o_disp_vsync)
    );

endmodule

// ==== verilog/box_overlay.sv ====
`timescale 1ns/1ns

module box_overlay #(
    parameter int N_BOX       = 2,
    parameter int H_BOX_WIDTH = 2,
    parameter int V_BOX_WIDTH = 1
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  aimbot_pkg::xcoord_t i_x,
    input  aimbot_pkg::ycoord_t i_y,
    input  aimbot_pkg::pix565_t i_pix,
    input  logic                i_de,
    input  logic                i_hsync,
    input  logic                i_vsync,
    input  aimbot_pkg::xcoord_t i_start_x [N_BOX],
    input  aimbot_pkg::ycoord_t i_start_y [N_BOX],
    input  aimbot_pkg::xcoord_t i_end_x [N_BOX],
    input  aimbot_pkg::ycoord_t i_end_y [N_BOX],
    input  logic                i_box_en [N_BOX],
    input  aimbot_pkg::rgb888_t i_color,
    output aimbot_pkg::rgb888_t o_rgb,
    output logic                o_de,
    output logic                o_hsync,
    output logic                o_vsync
);

    localparam aimbot_pkg::xcoord_t H_W = aimbot_pkg::xcoord_t'(H_BOX_WIDTH);
    localparam aimbot_pkg::ycoord_t V_W = aimbot_pkg::ycoord_t'(V_BOX_WIDTH);

    logic                on_border;
    aimbot_pkg::rgb888_t pix_rgb;

    always_comb begin : border_check
        logic in_box;
        logic near_x;
        logic near_y;
        on_border = 1'b0;
        for (int k = 0; k < N_BOX; k++) begin
            in_box = (i_x >= i_start_x[k]) && (i_x <= i_end_x[k]) &&
                     (i_y >= i_start_y[k]) && (i_y <= i_end_y[k]);
            // Differences cannot wrap while the pixel is inside the box.
            near_x = ((i_x - i_start_x[k]) < H_W) || ((i_end_x[k] - i_x) < H_W);
            near_y = ((i_y - i_start_y[k]) < V_W) || ((i_end_y[k] - i_y) < V_W);
            if (i_box_en[k] && in_box && (near_x || near_y)) begin
                on_border = 1'b1;
            end
        end
    end

    // Low bits are zero filled, no replication of the top bits.
    assign pix_rgb = {i_pix.r, 3'b000, i_pix.g, 2'b00, i_pix.b, 3'b000};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rgb   <= '0;
            o_de    <= 1'b0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
        end else begin
            o_de    <= i_de;
            o_hsync <= i_hsync;
            o_vsync <= i_vsync;
            if (i_de) begin
                o_rgb <= on_border ? i_color : pix_rgb;
            end
        end
    end

endmodule

// ==== verilog/cam_byte_packer.sv ====
`timescale 1ns/1ns

module cam_byte_packer (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_href,
    input  logic                i_vsync,
    input  logic                i_pclk_en,
    input  logic [7:0]          i_data,
    output aimbot_pkg::pix565_t o_pix,
    output logic                o_pix_valid,
    output logic                o_href,
    output logic                o_vsync
);

    logic       phase;     // High once the first byte of a pair is held.
    logic [7:0] hi_byte;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase       <= 1'b0;
            o_pix_valid <= 1'b0;
            o_href      <= 1'b0;
            o_vsync     <= 1'b0;
        end else begin
            // Syncs take the same single register stage as the pixel.
            o_href      <= i_href;
            o_vsync     <= i_vsync;
            o_pix_valid <= 1'b0;
            if (!i_href) begin
                phase <= 1'b0;
            end else if (i_pclk_en) begin
                phase       <= ~phase;
                o_pix_valid <= phase;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_href && i_pclk_en) begin
            if (!phase) begin
                hi_byte <= i_data;
            end else begin
                o_pix <= {hi_byte, i_data};
            end
        end
    end

endmodule

// ==== verilog/frame_timing.sv ====
`timescale 1ns/1ns

module frame_timing (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_cam_sel,
    input  aimbot_pkg::pix565_t i_cam1_pix,
    input  logic                i_cam1_pix_valid,
    input  logic                i_cam1_href,
    input  logic                i_cam1_vsync,
    input  aimbot_pkg::pix565_t i_cam2_pix,
    input  logic                i_cam2_pix_valid,
    input  logic                i_cam2_href,
    input  logic                i_cam2_vsync,
    output aimbot_pkg::xcoord_t o_x,
    output aimbot_pkg::ycoord_t o_y,
    output aimbot_pkg::pix565_t o_pix,
    output logic                o_de,
    output logic                o_hsync,
    output logic                o_vsync,
    output logic                o_frame_start
);

    aimbot_pkg::pix565_t sel_pix;
    logic                sel_valid;
    logic                sel_href;
    logic                sel_vsync;
    logic                href_d;
    logic                vsync_d;
    logic                href_fall;
    logic                vsync_fall;
    aimbot_pkg::xcoord_t x_cnt;
    aimbot_pkg::ycoord_t y_cnt;

    always_comb begin
        if (i_cam_sel) begin
            sel_pix   = i_cam2_pix;
            sel_valid = i_cam2_pix_valid;
            sel_href  = i_cam2_href;
            sel_vsync = i_cam2_vsync;
        end else begin
            sel_pix   = i_cam1_pix;
            sel_valid = i_cam1_pix_valid;
            sel_href  = i_cam1_href;
            sel_vsync = i_cam1_vsync;
        end
    end

    assign href_fall  = href_d & ~sel_href;
    assign vsync_fall = vsync_d & ~sel_vsync;   // The end of vertical blanking.

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            href_d        <= 1'b0;
            vsync_d       <= 1'b0;
            x_cnt         <= '0;
            y_cnt         <= '0;
            o_de          <= 1'b0;
            o_hsync       <= 1'b0;
            o_vsync       <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            href_d        <= sel_href;
            vsync_d       <= sel_vsync;
            o_de          <= sel_valid;
            o_hsync       <= sel_href;
            o_vsync       <= sel_vsync;
            o_frame_start <= vsync_fall;
            if (vsync_fall) begin
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (href_fall) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end else if (sel_valid) begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // The pixel leaves with the coordinates counted before it.
    always_ff @(posedge i_clk) begin
        if (sel_valid) begin
            o_pix <= sel_pix;
            o_x   <= x_cnt;
            o_y   <= y_cnt;
        end
    end

endmodule
